/* rtl/mmu_macros.svh */
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// tlb depth
`define MMU_TLB_ENTRIES 16

// sv32 address split
`define MMU_OFFSET_W 12
`define MMU_VPN_PART_W 10
`define MMU_PTE_BYTES 4

// pte flag bit positions
`define MMU_PTE_V 0
`define MMU_PTE_R 1
`define MMU_PTE_W 2
`define MMU_PTE_X 3
`define MMU_PTE_U 4

// exception codes
`define MMU_EXC_LOAD_ACCESS 5'd5
`define MMU_EXC_STORE_ACCESS 5'd7
`define MMU_EXC_LOAD_PAGE 5'd13
`define MMU_EXC_STORE_PAGE 5'd15

`endif

/* rtl/mmu_pkg.sv */
`include "mmu_macros.svh"

package mmu_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] vaddr_t;
   typedef logic [31:0] paddr_t;

   // both vpn levels, the tlb tag
   typedef logic [2*`MMU_VPN_PART_W-1:0] vpn_t;

   // full pte ppn, top two bits dropped when forming an address
   typedef logic [21:0] ppn_t;

   typedef logic [9:0] pte_flags_t;
   typedef logic [3:0] wstrb_t;
   typedef logic [4:0] exc_code_t;

   typedef enum logic [1:0] {
      PRIV_U = 2'd0,
      PRIV_S = 2'd1,
      PRIV_M = 2'd3
   } priv_t;

   typedef enum logic {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_mode_t;

   typedef enum logic {
      CAUSE_FETCH = 1'b0,
      CAUSE_MEM   = 1'b1
   } req_cause_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WALK_L1,
      ST_WALK_L0,
      ST_WAIT_MEM,
      ST_RESPOND
   } walk_state_t;

endpackage

/* rtl/req_capture.sv */
`timescale 1ns/1ns

module req_capture (
   input  logic                clk,
   input  logic                rstn,
   input  logic                fetch_request_enable,
   input  mmu_pkg::mem_mode_t  freq_mode,
   input  mmu_pkg::vaddr_t     freq_addr,
   input  mmu_pkg::word_t      freq_wdata,
   input  mmu_pkg::wstrb_t     freq_wstrb,
   input  logic                mem_request_enable,
   input  mmu_pkg::mem_mode_t  mreq_mode,
   input  mmu_pkg::vaddr_t     mreq_addr,
   input  mmu_pkg::word_t      mreq_wdata,
   input  mmu_pkg::wstrb_t     mreq_wstrb,
   input  logic                accept,
   output logic                req_valid,
   output mmu_pkg::req_cause_t sel_cause,
   output mmu_pkg::mem_mode_t  sel_mode,
   output mmu_pkg::vaddr_t     sel_addr,
   output mmu_pkg::word_t      sel_wdata,
   output mmu_pkg::wstrb_t     sel_wstrb,
   output mmu_pkg::req_cause_t held_cause,
   output mmu_pkg::mem_mode_t  held_mode,
   output mmu_pkg::vaddr_t     held_vaddr,
   output mmu_pkg::word_t      held_wdata,
   output mmu_pkg::wstrb_t     held_wstrb
);

   import mmu_pkg::*;

   // fetch wins a tie
   always_comb begin
      req_valid = fetch_request_enable | mem_request_enable;
      if (fetch_request_enable) begin
         sel_cause = CAUSE_FETCH;
         sel_mode  = freq_mode;
         sel_addr  = freq_addr;
         sel_wdata = freq_wdata;
         sel_wstrb = freq_wstrb;
      end else begin
         sel_cause = CAUSE_MEM;
         sel_mode  = mreq_mode;
         sel_addr  = mreq_addr;
         sel_wdata = mreq_wdata;
         sel_wstrb = mreq_wstrb;
      end
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         held_cause <= CAUSE_FETCH;
      end else if (accept) begin
         held_cause <= sel_cause;
      end
   end

   // used by the walk and the final access
   always_ff @(posedge clk) begin
      if (accept) begin
         held_mode  <= sel_mode;
         held_vaddr <= sel_addr;
         held_wdata <= sel_wdata;
         held_wstrb <= sel_wstrb;
      end
   end

endmodule

/* rtl/tlb.sv */
`timescale 1ns/1ns
`include "mmu_macros.svh"

module tlb #(
   parameter int NUM_ENTRIES = `MMU_TLB_ENTRIES
) (
   input  logic                clk,
   input  logic                rstn,
   input  mmu_pkg::vpn_t       lookup_vpn,
   input  logic                fill_en,
   input  mmu_pkg::vpn_t       fill_vpn,
   input  mmu_pkg::ppn_t       fill_ppn,
   input  mmu_pkg::pte_flags_t fill_flags,
   input  logic                flush,
   output logic                hit,
   output mmu_pkg::ppn_t       hit_ppn,
   output mmu_pkg::pte_flags_t hit_flags
);

   import mmu_pkg::*;

   localparam int IDX_W = $clog2(NUM_ENTRIES);

   logic [NUM_ENTRIES-1:0] valid;
   vpn_t                   tag   [NUM_ENTRIES];
   ppn_t                   ppn   [NUM_ENTRIES];
   pte_flags_t             flags [NUM_ENTRIES];
   logic [NUM_ENTRIES-1:0] fill_match;
   logic [IDX_W-1:0]       fill_idx;
   logic                   fill_we;

   ////////////////////////////////////////////////////////////
   // lookup, scanned downward so the lowest index wins
   always_comb begin
      hit       = 1'b0;
      hit_ppn   = '0;
      hit_flags = '0;
      for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
         if (valid[i] && tag[i] == lookup_vpn) begin
            hit       = 1'b1;
            hit_ppn   = ppn[i];
            hit_flags = flags[i];
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // fill slot: lowest invalid entry, else entry 0
   always_comb begin
      fill_idx = '0;
      for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
         fill_match[i] = valid[i] && tag[i] == fill_vpn;
         if (!valid[i]) begin
            fill_idx = IDX_W'(i);
         end
      end
   end

   // already mapped, keep the old entry
   assign fill_we = fill_en && fill_match == '0;

   always_ff @(posedge clk) begin
      if (rstn) begin
         valid <= '0;
      end else if (flush) begin
         valid <= '0;
      end else if (fill_we) begin
         valid[fill_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_we) begin
         tag[fill_idx]   <= fill_vpn;
         ppn[fill_idx]   <= fill_ppn;
         flags[fill_idx] <= fill_flags;
      end
   end

endmodule

/* rtl/pte_check.sv */
`timescale 1ns/1ns
`include "mmu_macros.svh"

module pte_check (
   input  mmu_pkg::pte_flags_t pte_flags,
   input  mmu_pkg::req_cause_t cause,
   input  mmu_pkg::mem_mode_t  mode,
   input  mmu_pkg::priv_t      cpu_mode,
   input  logic                sum,
   output logic                pte_invalid,
   output logic                pte_leaf,
   output logic                perm_ok
);

   import mmu_pkg::*;

   logic mode_ok;
   logic op_ok;

   // w without r is a reserved encoding
   assign pte_invalid = !pte_flags[`MMU_PTE_V] ||
                        (pte_flags[`MMU_PTE_W] && !pte_flags[`MMU_PTE_R]);
   assign pte_leaf    = pte_flags[`MMU_PTE_R] || pte_flags[`MMU_PTE_X];

   always_comb begin
      case (cpu_mode)
         PRIV_U:  mode_ok = pte_flags[`MMU_PTE_U];
         // user pages from s-mode only with sum
         PRIV_S:  mode_ok = !pte_flags[`MMU_PTE_U] || sum;
         PRIV_M:  mode_ok = 1'b1;
         default: mode_ok = 1'b0;
      endcase
   end

   always_comb begin
      if (cause == CAUSE_FETCH) begin
         op_ok = pte_flags[`MMU_PTE_X];
      end else if (mode == MEM_READ) begin
         op_ok = pte_flags[`MMU_PTE_R];
      end else begin
         op_ok = pte_flags[`MMU_PTE_W];
      end
   end

   assign perm_ok = mode_ok && op_ok;

endmodule

/* rtl/walk_ctrl.sv */
`timescale 1ns/1ns
`include "mmu_macros.svh"

module walk_ctrl (
   input  logic                clk,
   input  logic                rstn,
   input  mmu_pkg::word_t      satp,
   input  mmu_pkg::priv_t      actual_cpu_mode,
   input  logic                flush_tlb,
   input  logic                response_enable,
   input  mmu_pkg::word_t      resp_data,
   input  logic                req_valid,
   input  mmu_pkg::req_cause_t sel_cause,
   input  mmu_pkg::mem_mode_t  sel_mode,
   input  mmu_pkg::vaddr_t     sel_addr,
   input  mmu_pkg::word_t      sel_wdata,
   input  mmu_pkg::wstrb_t     sel_wstrb,
   input  mmu_pkg::req_cause_t held_cause,
   input  mmu_pkg::mem_mode_t  held_mode,
   input  mmu_pkg::vaddr_t     held_vaddr,
   input  mmu_pkg::word_t      held_wdata,
   input  mmu_pkg::wstrb_t     held_wstrb,
   input  logic                hit,
   input  mmu_pkg::ppn_t       hit_ppn,
   input  mmu_pkg::pte_flags_t hit_flags,
   input  logic                pte_invalid,
   input  logic                pte_leaf,
   input  logic                perm_ok,
   output logic                accept,
   output mmu_pkg::pte_flags_t check_flags,
   output mmu_pkg::req_cause_t check_cause,
   output mmu_pkg::mem_mode_t  check_mode,
   output logic                fill_en,
   output mmu_pkg::vpn_t       fill_vpn,
   output mmu_pkg::ppn_t       fill_ppn,
   output mmu_pkg::pte_flags_t fill_flags,
   output logic                tlb_flush,
   output logic                request_enable,
   output mmu_pkg::mem_mode_t  req_mode,
   output mmu_pkg::paddr_t     req_addr,
   output mmu_pkg::word_t      req_wdata,
   output mmu_pkg::wstrb_t     req_wstrb,
   output logic                fetch_response_enable,
   output mmu_pkg::word_t      fresp_data,
   output logic                mem_response_enable,
   output mmu_pkg::word_t      mresp_data,
   output logic                exception_enable,
   output mmu_pkg::exc_code_t  exception_vec,
   output mmu_pkg::vaddr_t     exception_tval
);

   import mmu_pkg::*;

   walk_state_t state;
   walk_state_t state_next;
   logic        in_idle, in_walk, bypass;
   logic        access_fault, walk_fault, fault_go;
   logic        data_done, resp_fetch, resp_mem;
   req_cause_t  cur_cause;
   mem_mode_t   cur_mode;
   vaddr_t      cur_vaddr;
   word_t       cur_wdata;
   wstrb_t      cur_wstrb;
   exc_code_t   fault_code;
   logic        issue;
   logic        pte_read;
   paddr_t      issue_addr;
   paddr_t      leaf_paddr;

   // table base plus index times pte size
   function automatic paddr_t pte_addr(input logic [19:0] base,
                                       input logic [`MMU_VPN_PART_W-1:0] idx);
      pte_addr = {base, {`MMU_OFFSET_W{1'b0}}} + paddr_t'(idx) * `MMU_PTE_BYTES;
   endfunction

   assign in_idle = state == ST_IDLE;
   assign in_walk = state == ST_WALK_L1 || state == ST_WALK_L0;
   assign accept  = in_idle && req_valid;

   // live request while idle, held one afterwards
   assign cur_cause = in_idle ? sel_cause : held_cause;
   assign cur_mode  = in_idle ? sel_mode : held_mode;
   assign cur_vaddr = in_idle ? sel_addr : held_vaddr;
   assign cur_wdata = in_idle ? sel_wdata : held_wdata;
   assign cur_wstrb = in_idle ? sel_wstrb : held_wstrb;

   // bare mode, or a fetch in machine mode
   assign bypass = !satp[31] || (actual_cpu_mode == PRIV_M && sel_cause == CAUSE_FETCH);

   assign check_flags = in_idle ? hit_flags : resp_data[9:0];
   assign check_cause = cur_cause;
   assign check_mode  = cur_mode;

   ////////////////////////////////////////////////////////////
   // fault detection
   assign access_fault = accept && !flush_tlb && !bypass && hit && !perm_ok;
   // level-1 leaf needs ppn[0] zero, level-0 must be a leaf
   assign walk_fault = in_walk && response_enable &&
                       (pte_invalid || (pte_leaf && !perm_ok) ||
                        (state == ST_WALK_L1 && pte_leaf && resp_data[19:10] != '0) ||
                        (state == ST_WALK_L0 && !pte_leaf));
   assign fault_go  = access_fault || walk_fault;
   assign data_done = state == ST_WAIT_MEM && response_enable;

   always_comb begin
      if (access_fault) begin
         fault_code = (cur_mode == MEM_READ) ? `MMU_EXC_LOAD_ACCESS : `MMU_EXC_STORE_ACCESS;
      end else begin
         fault_code = (cur_mode == MEM_READ) ? `MMU_EXC_LOAD_PAGE : `MMU_EXC_STORE_PAGE;
      end
   end

   ////////////////////////////////////////////////////////////
   // leaf translation and tlb fill
   assign leaf_paddr = (state == ST_WALK_L1) ? {resp_data[29:20], held_vaddr[21:0]}
                                             : {resp_data[29:10], held_vaddr[11:0]};
   assign fill_en    = in_walk && response_enable && pte_leaf && !walk_fault;
   assign fill_vpn   = held_vaddr[31:12];
   assign fill_ppn   = (state == ST_WALK_L1) ? {resp_data[31:20], held_vaddr[21:12]}
                                             : resp_data[31:10];
   assign fill_flags = resp_data[9:0];
   assign tlb_flush  = accept && flush_tlb;

   ////////////////////////////////////////////////////////////
   // next state and bus request
   always_comb begin
      state_next = state;
      issue      = 1'b0;
      pte_read   = 1'b0;
      issue_addr = '0;
      case (state)
         ST_IDLE: begin
            if (accept) begin
               if (flush_tlb || access_fault) begin
                  state_next = ST_RESPOND;
               end else if (bypass || hit) begin
                  issue      = 1'b1;
                  issue_addr = bypass ? sel_addr : {hit_ppn[19:0], sel_addr[11:0]};
                  state_next = ST_WAIT_MEM;
               end else begin
                  issue      = 1'b1;
                  pte_read   = 1'b1;
                  issue_addr = pte_addr(satp[19:0], sel_addr[31:22]);
                  state_next = ST_WALK_L1;
               end
            end
         end
         ST_WALK_L1, ST_WALK_L0: begin
            if (response_enable) begin
               if (walk_fault) begin
                  state_next = ST_RESPOND;
               end else if (pte_leaf) begin
                  issue      = 1'b1;
                  issue_addr = leaf_paddr;
                  state_next = ST_WAIT_MEM;
               end else begin
                  // pointer to the level-0 table
                  issue      = 1'b1;
                  pte_read   = 1'b1;
                  issue_addr = pte_addr(resp_data[29:10], held_vaddr[21:12]);
                  state_next = ST_WALK_L0;
               end
            end
         end
         ST_WAIT_MEM: begin
            if (response_enable) begin
               state_next = ST_RESPOND;
            end
         end
         default: state_next = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         state          <= ST_IDLE;
         request_enable <= 1'b0;
         req_mode       <= MEM_READ;
         req_addr       <= '0;
         req_wdata      <= '0;
         req_wstrb      <= '0;
      end else begin
         state          <= state_next;
         request_enable <= issue;
         if (issue) begin
            req_mode  <= pte_read ? MEM_READ : cur_mode;
            req_addr  <= issue_addr;
            req_wdata <= pte_read ? '0 : cur_wdata;
            req_wstrb <= pte_read ? '0 : cur_wstrb;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // responses and exceptions, flush always answers on mem side
   assign resp_fetch = (fault_go || data_done) && cur_cause == CAUSE_FETCH;
   assign resp_mem   = ((fault_go || data_done) && cur_cause == CAUSE_MEM) || tlb_flush;

   always_ff @(posedge clk) begin
      if (rstn) begin
         fetch_response_enable <= 1'b0;
         fresp_data            <= '0;
         mem_response_enable   <= 1'b0;
         mresp_data            <= '0;
         exception_enable      <= 1'b0;
         exception_vec         <= '0;
         exception_tval        <= '0;
      end else begin
         fetch_response_enable <= resp_fetch;
         mem_response_enable   <= resp_mem;
         if (resp_fetch) begin
            fresp_data <= data_done ? resp_data : '0;
         end
         if (resp_mem) begin
            mresp_data <= data_done ? resp_data : '0;
         end
         if (fault_go) begin
            exception_enable <= 1'b1;
            exception_vec    <= fault_code;
            exception_tval   <= cur_vaddr;
         end else if (accept) begin
            exception_enable <= 1'b0;
            exception_vec    <= '0;
         end
      end
   end

endmodule

/* rtl/mmu_top.sv */
`timescale 1ns/1ns

module mmu_top (
   input  logic                clk,
   input  logic                rstn,
   input  mmu_pkg::word_t      satp,
   input  mmu_pkg::priv_t      cpu_mode,
   input  mmu_pkg::priv_t      actual_cpu_mode,
   input  logic                sum,
   input  logic                flush_tlb,
   input  logic                fetch_request_enable,
   input  mmu_pkg::mem_mode_t  freq_mode,
   input  mmu_pkg::vaddr_t     freq_addr,
   input  mmu_pkg::word_t      freq_wdata,
   input  mmu_pkg::wstrb_t     freq_wstrb,
   output logic                fetch_response_enable,
   output mmu_pkg::word_t      fresp_data,
   input  logic                mem_request_enable,
   input  mmu_pkg::mem_mode_t  mreq_mode,
   input  mmu_pkg::vaddr_t     mreq_addr,
   input  mmu_pkg::word_t      mreq_wdata,
   input  mmu_pkg::wstrb_t     mreq_wstrb,
   output logic                mem_response_enable,
   output mmu_pkg::word_t      mresp_data,
   output logic                exception_enable,
   output mmu_pkg::exc_code_t  exception_vec,
   output mmu_pkg::vaddr_t     exception_tval,
   output logic                request_enable,
   output mmu_pkg::mem_mode_t  req_mode,
   output mmu_pkg::paddr_t     req_addr,
   output mmu_pkg::word_t      req_wdata,
   output mmu_pkg::wstrb_t     req_wstrb,
   input  logic                response_enable,
   input  mmu_pkg::word_t      resp_data
);

   import mmu_pkg::*;

   // request capture
   logic       accept;
   logic       req_valid;
   req_cause_t sel_cause, held_cause;
   mem_mode_t  sel_mode, held_mode;
   vaddr_t     sel_addr, held_vaddr;
   word_t      sel_wdata, held_wdata;
   wstrb_t     sel_wstrb, held_wstrb;

   // tlb
   logic       hit;
   ppn_t       hit_ppn;
   pte_flags_t hit_flags;
   logic       fill_en;
   vpn_t       fill_vpn;
   ppn_t       fill_ppn;
   pte_flags_t fill_flags;
   logic       tlb_flush;

   // permission check
   pte_flags_t check_flags;
   req_cause_t check_cause;
   mem_mode_t  check_mode;
   logic       pte_invalid;
   logic       pte_leaf;
   logic       perm_ok;

   req_capture i_req_capture (.*);

   tlb i_tlb (
      .*,
      .lookup_vpn (sel_addr[31:12]),
      .flush      (tlb_flush)
   );

   pte_check i_pte_check (
      .*,
      .pte_flags (check_flags),
      .cause     (check_cause),
      .mode      (check_mode)
   );

   walk_ctrl i_walk_ctrl (.*);

endmodule

/* tb/mmu_top_tb.sv */
`timescale 1ns/1ns
`include "mmu_macros.svh"

module mmu_top_tb;

   import mmu_pkg::*;

   localparam int          NUM_REQ     = 400;
   localparam int          RESET_CYC   = 16;
   localparam int          CYCLE_LIMIT = NUM_REQ * 40 + RESET_CYC;
   localparam logic [19:0] ROOT_PPN    = 20'h00100;

   logic       clk;
   logic       rstn;
   word_t      satp;
   priv_t      cpu_mode;
   priv_t      actual_cpu_mode;
   logic       sum;
   logic       flush_tlb;
   logic       fetch_request_enable;
   mem_mode_t  freq_mode;
   vaddr_t     freq_addr;
   word_t      freq_wdata;
   wstrb_t     freq_wstrb;
   logic       fetch_response_enable;
   word_t      fresp_data;
   logic       mem_request_enable;
   mem_mode_t  mreq_mode;
   vaddr_t     mreq_addr;
   word_t      mreq_wdata;
   wstrb_t     mreq_wstrb;
   logic       mem_response_enable;
   word_t      mresp_data;
   logic       exception_enable;
   exc_code_t  exception_vec;
   vaddr_t     exception_tval;
   logic       request_enable;
   mem_mode_t  req_mode;
   paddr_t     req_addr;
   word_t      req_wdata;
   wstrb_t     req_wstrb;
   logic       response_enable;
   word_t      resp_data;

   word_t      mem [paddr_t];
   int         seed = 49;
   int         mem_seed = 49;
   int         bus_count;
   mem_mode_t  last_mode;
   paddr_t     last_addr;
   word_t      last_wdata;
   wstrb_t     last_wstrb;
   int         errors;
   int         checks;
   int         cycles;

   // reference copy of the tlb
   logic       m_valid [`MMU_TLB_ENTRIES];
   vpn_t       m_tag   [`MMU_TLB_ENTRIES];
   ppn_t       m_ppn   [`MMU_TLB_ENTRIES];
   pte_flags_t m_flags [`MMU_TLB_ENTRIES];

   mmu_top i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // memory contents and page tables
   function automatic word_t mem_word(input paddr_t addr);
      if (mem.exists(addr)) begin
         return mem[addr];
      end
      // untouched locations
      return addr ^ 32'h5a3c_96e1;
   endfunction

   function automatic word_t make_pte(input ppn_t ppn, input pte_flags_t flags);
      return {ppn, flags};
   endfunction

   task automatic build_tables();
      int     r;
      paddr_t base;
      mem[{ROOT_PPN, 12'h000}] = make_pte(22'h00101, 10'h001);
      mem[{ROOT_PPN, 12'h004}] = make_pte(22'h00102, 10'h001);
      mem[{ROOT_PPN, 12'h008}] = make_pte({12'h0a5, 10'h000}, 10'h00f);
      mem[{ROOT_PPN, 12'h00c}] = make_pte({12'h0c3, 10'h000}, 10'h017);
      // misaligned superpage
      mem[{ROOT_PPN, 12'h010}] = make_pte({12'h0e1, 10'h004}, 10'h00f);
      mem[{ROOT_PPN, 12'h014}] = 32'h0;
      // upper ppn bits are set and dropped in the address
      mem[{ROOT_PPN, 12'h018}] = make_pte({12'hc12, 10'h000}, 10'h01b);
      mem[{ROOT_PPN, 12'h01c}] = make_pte(22'h00103, 10'h005);
      for (int t = 1; t <= 2; t++) begin
         for (int i = 0; i < 8; i++) begin
            r         = $random(seed);
            base      = 32'h0010_0000 + t * 4096 + i * 4;
            mem[base] = make_pte(r[29:8], {5'd0, r[4:1], r[7:5] != 3'd0});
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // translation model
   function automatic logic pte_bad(input word_t pte);
      return !pte[`MMU_PTE_V] || (pte[`MMU_PTE_W] && !pte[`MMU_PTE_R]);
   endfunction

   function automatic logic pte_is_leaf(input word_t pte);
      return pte[`MMU_PTE_R] || pte[`MMU_PTE_X];
   endfunction

   function automatic logic perm_allows(input pte_flags_t f, input logic is_fetch,
                                        input mem_mode_t mode);
      logic mode_ok;
      logic op_ok;
      case (cpu_mode)
         PRIV_U:  mode_ok = f[`MMU_PTE_U];
         PRIV_S:  mode_ok = !f[`MMU_PTE_U] || sum;
         default: mode_ok = 1'b1;
      endcase
      op_ok = is_fetch ? f[`MMU_PTE_X] :
              (mode == MEM_WRITE) ? f[`MMU_PTE_W] : f[`MMU_PTE_R];
      return mode_ok && op_ok;
   endfunction

   function automatic int find_entry(input vpn_t vpn);
      int found;
      found = -1;
      for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--) begin
         if (m_valid[i] && m_tag[i] == vpn) begin
            found = i;
         end
      end
      return found;
   endfunction

   task automatic tlb_clear();
      for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
         m_valid[i] = 1'b0;
      end
   endtask

   task automatic tlb_fill(input vpn_t vpn, input ppn_t ppn, input pte_flags_t flags);
      int slot;
      slot = 0;
      if (find_entry(vpn) < 0) begin
         for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (!m_valid[i]) begin
               slot = i;
            end
         end
         m_valid[slot] = 1'b1;
         m_tag[slot]   = vpn;
         m_ppn[slot]   = ppn;
         m_flags[slot] = flags;
      end
   endtask

   task automatic predict_response(input logic is_flush, input logic is_fetch,
                                   input mem_mode_t mode, input vaddr_t va,
                                   output logic fault, output exc_code_t code,
                                   output paddr_t pa, output int nbus);
      int    idx;
      word_t pte1;
      word_t pte0;
      fault = 1'b0;
      pa    = '0;
      nbus  = 0;
      code  = (mode == MEM_WRITE) ? `MMU_EXC_STORE_PAGE : `MMU_EXC_LOAD_PAGE;
      idx   = find_entry(va[31:12]);
      if (is_flush) begin
         tlb_clear();
      end else if (!satp[31] || (is_fetch && actual_cpu_mode == PRIV_M)) begin
         pa   = va;
         nbus = 1;
      end else if (idx >= 0) begin
         if (perm_allows(m_flags[idx], is_fetch, mode)) begin
            pa   = {m_ppn[idx][19:0], va[11:0]};
            nbus = 1;
         end else begin
            fault = 1'b1;
            code  = (mode == MEM_WRITE) ? `MMU_EXC_STORE_ACCESS : `MMU_EXC_LOAD_ACCESS;
         end
      end else begin
         pte1 = mem_word({satp[19:0], 12'h000} + {20'd0, va[31:22], 2'b00});
         nbus = 1;
         if (pte_bad(pte1)) begin
            fault = 1'b1;
         end else if (pte_is_leaf(pte1)) begin
            if (!perm_allows(pte1[9:0], is_fetch, mode) || pte1[19:10] != '0) begin
               fault = 1'b1;
            end else begin
               pa   = {pte1[29:20], va[21:0]};
               nbus = 2;
               tlb_fill(va[31:12], {pte1[31:20], va[21:12]}, pte1[9:0]);
            end
         end else begin
            pte0 = mem_word({pte1[29:10], 12'h000} + {20'd0, va[21:12], 2'b00});
            nbus = 2;
            if (pte_bad(pte0) || !pte_is_leaf(pte0) ||
                !perm_allows(pte0[9:0], is_fetch, mode)) begin
               fault = 1'b1;
            end else begin
               pa   = {pte0[29:10], va[11:0]};
               nbus = 3;
               tlb_fill(va[31:12], pte0[31:10], pte0[9:0]);
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // bus memory with one access in flight
   initial begin : memory_model
      int     lat;
      paddr_t addr;
      response_enable = 1'b0;
      resp_data       = '0;
      bus_count       = 0;
      forever begin
         @(negedge clk);
         response_enable = 1'b0;
         if (request_enable) begin
            bus_count++;
            addr       = req_addr;
            last_addr  = req_addr;
            last_mode  = req_mode;
            last_wdata = req_wdata;
            last_wstrb = req_wstrb;
            lat        = 1 + ($random(mem_seed) & 3);
            repeat (lat - 1) begin
               @(negedge clk);
            end
            response_enable = 1'b1;
            resp_data       = mem_word(addr);
         end
      end
   end

   task automatic run_request();
      int        r;
      logic      is_flush;
      logic      is_fetch;
      mem_mode_t mode;
      vaddr_t    va;
      word_t     wd;
      wstrb_t    ws;
      logic      exp_fault;
      exc_code_t exp_code;
      paddr_t    exp_addr;
      int        exp_bus;
      word_t     exp_data;
      string     data_name;
      @(negedge clk);
      r        = $random(seed);
      is_flush = r[4:0] == 5'd0;
      is_fetch = !is_flush && r[5];
      mode     = is_fetch ? MEM_READ : mem_mode_t'(r[6]);
      va       = {7'd0, r[9:7], 7'd0, r[12:10], r[22:13], 2'b00};
      if (r[24:23] == 2'd3) begin
         cpu_mode = PRIV_M;
      end else begin
         cpu_mode = r[23] ? PRIV_S : PRIV_U;
      end
      actual_cpu_mode = (r[26:25] == 2'd0) ? PRIV_M : cpu_mode;
      sum             = r[27];
      satp            = {r[30:28] != 3'd0, 11'd0, ROOT_PPN};
      wd              = $random(seed);
      ws              = wd[31:28];
      predict_response(is_flush, is_fetch, mode, va, exp_fault, exp_code, exp_addr, exp_bus);
      exp_data = (exp_fault || is_flush) ? 32'h0 : mem_word(exp_addr);

      // the idle side carries inverted fields
      bus_count            = 0;
      flush_tlb            = is_flush;
      fetch_request_enable = is_fetch;
      mem_request_enable   = !is_fetch;
      freq_mode            = is_fetch ? mode : mem_mode_t'(!mode);
      mreq_mode            = is_fetch ? mem_mode_t'(!mode) : mode;
      freq_addr            = is_fetch ? va : ~va;
      mreq_addr            = is_fetch ? ~va : va;
      freq_wdata           = is_fetch ? wd : ~wd;
      mreq_wdata           = is_fetch ? ~wd : wd;
      freq_wstrb           = is_fetch ? ws : ~ws;
      mreq_wstrb           = is_fetch ? ~ws : ws;

      @(negedge clk);
      while (!fetch_response_enable && !mem_response_enable) begin
         @(negedge clk);
      end

      check_value("fetch_response_enable", 32'(fetch_response_enable), 32'(is_fetch));
      check_value("mem_response_enable", 32'(mem_response_enable), 32'(!is_fetch));
      check_value("exception_enable", 32'(exception_enable), 32'(exp_fault));
      check_value("bus request count", bus_count, exp_bus);
      if (is_fetch) begin
         data_name = "fresp_data";
         check_value(data_name, fresp_data, exp_data);
      end else begin
         data_name = "mresp_data";
         check_value(data_name, mresp_data, exp_data);
      end
      if (exp_fault) begin
         check_value("exception_vec", 32'(exception_vec), 32'(exp_code));
         check_value("exception_tval", exception_tval, va);
      end else if (!is_flush) begin
         check_value("req_addr", last_addr, exp_addr);
         check_value("req_mode", 32'(last_mode), 32'(mode));
         check_value("req_wdata", last_wdata, wd);
         check_value("req_wstrb", 32'(last_wstrb), 32'(ws));
      end

      fetch_request_enable = 1'b0;
      mem_request_enable   = 1'b0;
      flush_tlb            = 1'b0;
   endtask

   initial begin : watchdog
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      rstn                 = 1'b1;
      satp                 = '0;
      cpu_mode             = PRIV_M;
      actual_cpu_mode      = PRIV_M;
      sum                  = 1'b0;
      flush_tlb            = 1'b0;
      fetch_request_enable = 1'b0;
      freq_mode            = MEM_READ;
      freq_addr            = '0;
      freq_wdata           = '0;
      freq_wstrb           = '0;
      mem_request_enable   = 1'b0;
      mreq_mode            = MEM_READ;
      mreq_addr            = '0;
      mreq_wdata           = '0;
      mreq_wstrb           = '0;
      errors               = 0;
      checks               = 0;
      tlb_clear();
      build_tables();

      repeat (RESET_CYC) @(posedge clk);
      @(negedge clk);
      rstn = 1'b0;
      @(negedge clk);
      check_value("request_enable", 32'(request_enable), 32'h0);
      check_value("fetch_response_enable", 32'(fetch_response_enable), 32'h0);
      check_value("mem_response_enable", 32'(mem_response_enable), 32'h0);
      check_value("exception_enable", 32'(exception_enable), 32'h0);
      check_value("fresp_data", fresp_data, 32'h0);
      check_value("mresp_data", mresp_data, 32'h0);

      for (int n = 0; n < NUM_REQ; n++) begin
         run_request();
      end

      @(negedge clk);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* mmu_top.f */
+incdir+rtl
rtl/mmu_pkg.sv
rtl/req_capture.sv
rtl/tlb.sv
rtl/pte_check.sv
rtl/walk_ctrl.sv
rtl/mmu_top.sv
tb/mmu_top_tb.sv

/* Makefile */
# Verilator build and run for the Sv32 MMU testbench

VERILATOR ?= verilator
TOP       ?= mmu_top_tb
FILELIST  ?= mmu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
SOURCES   := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
